//--- sim.f
verilog/sm83Pkg.sv
verilog/sm83Alu.sv
verilog/sm83Core.sv
verilog/irqControl.sv
verilog/oamDma.sv
verilog/busArbiter.sv
verilog/sysMemory.sv
verilog/sm83System.sv
sim/sm83SystemTb.sv

//--- Bender.yml
package:
  name: sm83System

sources:
  - verilog/sm83Pkg.sv
  - verilog/sm83Alu.sv
  - verilog/sm83Core.sv
  - verilog/irqControl.sv
  - verilog/oamDma.sv
  - verilog/busArbiter.sv
  - verilog/sysMemory.sv
  - verilog/sm83System.sv
  - target: simulation
    files:
      - sim/sm83SystemTb.sv

//--- sim/sm83SystemTb.sv
`timescale 1ns/100ps
`default_nettype none

module sm83SystemTb;

	logic clk, reset, serialStrobe;
	logic [sm83Pkg::irqCount-1:0] irqTrig;
	logic [7:0] serialData;
	logic [7:0] expected[$];    // Serial bytes still to come
	int loc, instrCount, errors, checks, cycles, dmaCycles;

	sm83System dut (.clk, .reset, .irqTrig, .serialData, .serialStrobe);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Returns {carry, result} by the SM83 accumulator rules
	function automatic logic [8:0] aluRef(input logic [2:0] op, input logic [7:0] a,
		input logic [7:0] b, input logic cin);
		logic [8:0] wide;
		case (op)
			sm83Pkg::aluAdd: wide = {1'b0, a} + {1'b0, b};
			sm83Pkg::aluAdc: wide = {1'b0, a} + {1'b0, b} + {8'd0, cin};
			sm83Pkg::aluSub, sm83Pkg::aluCp: wide = {1'b0, a} - {1'b0, b};  // Bit 8 is borrow
			sm83Pkg::aluSbc: wide = {1'b0, a} - {1'b0, b} - {8'd0, cin};
			sm83Pkg::aluAnd: wide = {1'b0, a & b};
			sm83Pkg::aluXor: wide = {1'b0, a ^ b};
			default: wide = {1'b0, a | b};
		endcase
		if (op == sm83Pkg::aluCp)
			wide[7:0] = a;          // Compare leaves A alone
		return wide;
	endfunction

	task automatic checkValue(input string name, input logic [7:0] want, input logic [7:0] got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED %s expected %h got %h", name, want, got);
		end
	endtask

	task automatic putInstr(input int len, input logic [7:0] b0, input logic [7:0] b1,
		input logic [7:0] b2);
		dut.mem.ram[loc] = b0;
		if (len > 1)
			dut.mem.ram[loc + 1] = b1;
		if (len > 2)
			dut.mem.ram[loc + 2] = b2;  // a16 high byte
		loc += len;
		instrCount++;               // Feeds the timeout limit
	endtask

	task automatic ldA(input logic [7:0] d);
		putInstr(2, 8'h3E, d, 8'h00);
	endtask

	task automatic storeA(input logic [15:0] a);
		putInstr(3, 8'hEA, a[7:0], a[15:8]);
	endtask

	task automatic loadA(input logic [15:0] a);
		putInstr(3, 8'hFA, a[7:0], a[15:8]);
	endtask

	task automatic jump(input logic [15:0] a);
		putInstr(3, 8'hC3, a[7:0], a[15:8]);
	endtask

	task automatic putOut(input logic [7:0] d);
		ldA(d);
		storeA(sm83Pkg::addrSerial);
	endtask

	// Handler at the line's vector emits 0xA0 plus the line, then RETI
	task automatic putHandler(input int line);
		loc = 16'h0040 + 8 * line;
		putOut(8'(8'hA0 + line));
		putInstr(1, 8'hD9, 8'h00, 8'h00);
	endtask

	task automatic beginProgram();
		reset <= 1'b1;
		repeat (2) @(posedge clk);  // Last write of the old program has landed
		loc = 0;
	endtask

	task automatic releaseReset();
		jump(16'(loc));             // Park on a jump to itself
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic waitQueue(input int n);
		while (expected.size() > n)
			@(posedge clk);
	endtask

	always @(negedge clk) begin
		if (dut.dmaRequest)
			dmaCycles++;
		if (dut.coreRequest && !dut.coreGrant && !dut.dmaRequest) begin
			errors++;
			$display("Core was held off the bus with no DMA copy running");
		end
		if (serialStrobe && expected.size() == 0) begin
			errors++;
			$display("Serial write of %h arrived with no byte expected", serialData);
		end else if (serialStrobe)
			checkValue("serialData", expected.pop_front(), serialData);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * instrCount + 200) begin
			$display("Timeout after %0d cycles with %0d bytes pending", cycles, expected.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [7:0] a, d, v;
		logic [8:0] res;
		logic [2:0] op;
		logic carry;
		logic [7:0] src [16];
		int k;
		reset = 1'b1;
		irqTrig = '0;
		void'($urandom(32'h6414));

		// Random ALU chain with the carry carried over
		beginProgram();
		carry = 1'b0;
		for (int i = 0; i < 40; i++) begin
			a = 8'($urandom);
			d = 8'($urandom);
			op = 3'($urandom);
			res = aluRef(op, a, d, carry);
			carry = res[8];
			ldA(a);
			putInstr(2, {2'b11, op, 3'b110}, d, 8'h00);
			storeA(sm83Pkg::addrSerial);
			expected.push_back(res[7:0]);
		end
		releaseReset();
		waitQueue(0);

		// RAM round trip around a skipped block
		beginProgram();
		v = 8'($urandom);
		ldA(v);
		storeA(16'h0900);
		jump(16'h0020);
		putOut(~v);                 // Must never run
		loc = 16'h0020;
		ldA(~v);
		loadA(16'h0900);
		storeA(sm83Pkg::addrSerial);
		expected.push_back(v);
		releaseReset();
		waitQueue(0);

		// Lines 0 and 2 raised together
		beginProgram();
		jump(16'h0100);
		putHandler(0);
		putHandler(2);
		loc = 16'h0100;
		ldA(8'h05);
		storeA(sm83Pkg::addrIe);
		putInstr(1, 8'hFB, 8'h00, 8'h00);  // EI
		putOut(8'h11);
		for (int i = 0; i < 20; i++)
			putInstr(1, 8'h00, 8'h00, 8'h00);
		putOut(8'h12);
		expected.push_back(8'h11);
		expected.push_back(8'hA0);  // Lower line first
		expected.push_back(8'hA2);
		expected.push_back(8'h12);
		releaseReset();
		waitQueue(3);
		irqTrig <= 5'b00101;
		@(posedge clk);
		irqTrig <= '0;
		waitQueue(0);

		// Masked line 3, then HALT woken by line 0
		beginProgram();
		jump(16'h0100);
		putHandler(0);
		putHandler(3);
		loc = 16'h0100;
		ldA(8'h01);
		storeA(sm83Pkg::addrIe);
		putInstr(1, 8'hFB, 8'h00, 8'h00);
		putOut(8'h21);
		putInstr(1, 8'h76, 8'h00, 8'h00);  // HALT
		putOut(8'h5A);
		expected.push_back(8'h21);
		expected.push_back(8'hA0);
		expected.push_back(8'h5A);
		releaseReset();
		waitQueue(2);
		irqTrig <= 5'b01000;
		repeat (30) @(posedge clk);
		checkValue("pendingBytes", 8'd2, 8'(expected.size()));  // Still halted
		irqTrig <= 5'b01001;
		@(posedge clk);
		irqTrig <= '0;
		waitQueue(0);

		// DMA copy of page 0x08 while the core wants the bus
		beginProgram();
		for (int i = 0; i < 16; i++) begin
			src[i] = 8'($urandom);
			dut.mem.ram[16'h0800 + i] = src[i];
			dut.mem.ram[sm83Pkg::oamBase + i] = ~src[i];  // Stale OAM differs
		end
		ldA(8'h08);
		storeA(sm83Pkg::addrDma);
		for (int j = 0; j < 5; j++) begin
			k = (j * 15) / 4;
			loadA(sm83Pkg::oamBase + 16'(k));
			storeA(sm83Pkg::addrSerial);
			expected.push_back(src[k]);
		end
		releaseReset();
		waitQueue(0);
		checkValue("dmaBusyCycles", 8'(2 * sm83Pkg::dmaLength), 8'(dmaCycles));

		repeat (20) @(posedge clk);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/sm83System.sv
`timescale 1ns/100ps
`default_nettype none

module sm83System (
	input wire logic clk,
	input wire logic reset,
	input wire logic [sm83Pkg::irqCount-1:0] irqTrig,
	output logic [7:0] serialData,
	output logic serialStrobe
);

	sm83Pkg::busReqT coreReq, dmaReq, memReq;
	logic coreRequest, coreGrant, dmaRequest, dmaGrant, memValid;
	logic [7:0] rdata, irqWdata, dmaPage;
	logic [sm83Pkg::irqCount-1:0] ifValue, ieValue;
	logic irqValid, irqAck, irqRegWrite, irqSelIe, dmaStart;
	logic [2:0] irqPending;

	sm83Core core (
		.clk, .reset, .busReq(coreReq), .busRequest(coreRequest), .busGrant(coreGrant),
		.rdata, .irqValid, .irqPending, .irqAck
	);

	busArbiter arb (
		.coreReq, .coreRequest, .dmaReq, .dmaRequest,
		.coreGrant, .dmaGrant, .memReq, .memValid
	);

	oamDma dma (
		.clk, .reset, .start(dmaStart), .sourcePage(dmaPage),
		.busReq(dmaReq), .busRequest(dmaRequest), .busGrant(dmaGrant), .rdata
	);

	irqControl irq (
		.clk, .reset, .irqTrig, .regWrite(irqRegWrite), .regSelIe(irqSelIe),
		.wdata(irqWdata), .ifValue, .ieValue, .irqValid, .irqPending, .irqAck
	);

	sysMemory mem (
		.clk, .memReq, .memValid, .rdata, .ifValue, .ieValue, .irqRegWrite, .irqSelIe,
		.irqWdata, .dmaStart, .dmaPage, .serialData, .serialStrobe  // SB to the outside
	);

endmodule

`default_nettype wire

//--- verilog/sysMemory.sv
`timescale 1ns/100ps
`default_nettype none

module sysMemory (
	input wire logic clk,
	input wire sm83Pkg::busReqT memReq,
	input wire logic memValid,
	output logic [7:0] rdata,
	input wire logic [sm83Pkg::irqCount-1:0] ifValue,
	input wire logic [sm83Pkg::irqCount-1:0] ieValue,
	output logic irqRegWrite,
	output logic irqSelIe,
	output logic [7:0] irqWdata,
	output logic dmaStart,
	output logic [7:0] dmaPage,
	output logic [7:0] serialData,
	output logic serialStrobe
);

	logic [7:0] ram [sm83Pkg::ramBytes];
	logic [$clog2(sm83Pkg::ramBytes)-1:0] ramAddr;
	logic isIf, isIe, isRam, doWrite;

	assign ramAddr = memReq.addr[$clog2(sm83Pkg::ramBytes)-1:0];
	assign isIf = (memReq.addr == sm83Pkg::addrIf);
	assign isIe = (memReq.addr == sm83Pkg::addrIe);
	assign isRam = (int'(memReq.addr) < sm83Pkg::ramBytes);
	assign doWrite = memValid && memReq.we;

	assign irqRegWrite = doWrite && (isIf || isIe);
	assign irqSelIe = isIe;
	assign irqWdata = memReq.wdata;
	assign dmaStart = doWrite && (memReq.addr == sm83Pkg::addrDma);
	assign dmaPage = memReq.wdata;
	assign serialStrobe = doWrite && (memReq.addr == sm83Pkg::addrSerial);  // Same cycle out
	assign serialData = memReq.wdata;

	always_ff @(posedge clk) begin
		if (doWrite && isRam)
			ram[ramAddr] <= memReq.wdata;
		if (isIf)
			rdata <= {3'b111, ifValue};  // Unused IF/IE bits read high
		else if (isIe)
			rdata <= {3'b111, ieValue};
		else
			rdata <= ram[ramAddr];
	end

endmodule

`default_nettype wire

//--- verilog/busArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module busArbiter (
	input wire sm83Pkg::busReqT coreReq,
	input wire logic coreRequest,
	input wire sm83Pkg::busReqT dmaReq,
	input wire logic dmaRequest,
	output logic coreGrant,
	output logic dmaGrant,
	output sm83Pkg::busReqT memReq,
	output logic memValid
);

	assign dmaGrant = dmaRequest;                  // DMA has fixed priority
	assign coreGrant = coreRequest && !dmaRequest;
	assign memValid = dmaGrant || coreGrant;
	assign memReq = dmaGrant ? dmaReq : coreReq;   // Winner's request to memory

endmodule

`default_nettype wire

//--- verilog/oamDma.sv
`timescale 1ns/100ps
`default_nettype none

module oamDma (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic [7:0] sourcePage,
	output sm83Pkg::busReqT busReq,
	output logic busRequest,
	input wire logic busGrant,
	input wire logic [7:0] rdata
);

	logic busy, writePhase;
	logic [$clog2(sm83Pkg::dmaLength)-1:0] index;
	logic [7:0] page;           // Source high byte

	assign busRequest = busy;
	assign busReq.addr = writePhase ? sm83Pkg::oamBase + 16'(index) : {page, 8'(index)};
	assign busReq.wdata = rdata;  // Read result lands in the write cycle
	assign busReq.we = writePhase;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			writePhase <= 1'b0;
			index <= '0;
		end else if (start) begin
			busy <= 1'b1;
			writePhase <= 1'b0;
			index <= '0;
		end else if (busy && busGrant) begin
			writePhase <= !writePhase;
			if (writePhase) begin
				index <= index + 1'b1;
				busy <= (int'(index) != sm83Pkg::dmaLength - 1);  // Done after last write
			end
		end
	end

	always_ff @(posedge clk)
		if (start) page <= sourcePage;

	// Restart only comes from the core, which is locked out while copying
	noRestart: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

//--- verilog/irqControl.sv
`timescale 1ns/100ps
`default_nettype none

module irqControl (
	input wire logic clk,
	input wire logic reset,
	input wire logic [sm83Pkg::irqCount-1:0] irqTrig,
	input wire logic regWrite,
	input wire logic regSelIe,
	input wire logic [7:0] wdata,
	output logic [sm83Pkg::irqCount-1:0] ifValue,
	output logic [sm83Pkg::irqCount-1:0] ieValue,
	output logic irqValid,
	output logic [2:0] irqPending,
	input wire logic irqAck
);

	logic [sm83Pkg::irqCount-1:0] trigPrev, ifReg, ieReg, edges, active, ackMask;

	assign edges = irqTrig & ~trigPrev;  // Rising edges only
	assign active = ifReg & ieReg;
	assign irqValid = |active;
	assign ifValue = ifReg;
	assign ieValue = ieReg;

	always_comb begin
		irqPending = 3'd0;
		for (int i = sm83Pkg::irqCount - 1; i >= 0; i--) begin
			if (active[i])
				irqPending = 3'(i);  // Lowest line wins
		end
		ackMask = '0;
		if (irqAck)
			ackMask[irqPending] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			trigPrev <= '0;
			ifReg <= '0;
			ieReg <= '0;
		end else begin
			trigPrev <= irqTrig;
			if (regWrite && regSelIe)
				ieReg <= wdata[sm83Pkg::irqCount-1:0];
			if (regWrite && !regSelIe)
				ifReg <= (wdata[sm83Pkg::irqCount-1:0] | edges) & ~ackMask;
			else
				ifReg <= (ifReg | edges) & ~ackMask;  // Ack clears the served line
		end
	end

	// Core only acknowledges a live request
	ackLive: assert property (@(posedge clk) disable iff (reset) irqAck |-> irqValid);

endmodule

`default_nettype wire

//--- verilog/sm83Core.sv
`timescale 1ns/100ps
`default_nettype none

module sm83Core (
	input wire logic clk,
	input wire logic reset,
	output sm83Pkg::busReqT busReq,
	output logic busRequest,
	input wire logic busGrant,
	input wire logic [7:0] rdata,
	input wire logic irqValid,
	input wire logic [2:0] irqPending,
	output logic irqAck
);

	typedef enum logic [3:0] {
		sFetch, sImm, sAddrLo, sAddrHi, sMemRead, sMemWrite, sPopLo, sPopHi,
		sIntA, sIntB, sPushHi, sPushLo, sHalt, sBoundary
	} stateE;

	stateE state;
	logic dataPhase;            // Second cycle of a granted access
	logic accessState;
	logic [15:0] pc, sp, addrReg;
	logic [7:0] acc, aluResult;
	sm83Pkg::flagsT flags, aluFlags;
	sm83Pkg::opcodeU ir, fetched;
	logic ime, eiDelay;         // EI lands one instruction late
	logic [2:0] irqLine;

	assign fetched = rdata;
	assign accessState = !(state inside {sIntA, sIntB, sHalt, sBoundary});
	assign busRequest = accessState && !dataPhase;
	assign irqAck = (state == sBoundary) && ime && irqValid;  // Dispatch starts here

	sm83Alu alu (
		.op(sm83Pkg::aluOpE'(ir.f.y)),
		.a(acc), .b(rdata), .carryIn(flags.c),
		.result(aluResult), .flags(aluFlags)
	);

	always_comb begin
		busReq = '{addr: pc, wdata: acc, we: 1'b0};  // Fetch and operand reads
		case (state)
			sMemRead: busReq.addr = addrReg;
			sMemWrite: begin
				busReq.addr = addrReg;
				busReq.we = 1'b1;
			end
			sPopLo, sPopHi: busReq.addr = sp;
			sPushHi, sPushLo: begin
				busReq.addr = sp - 16'd1;  // Pre-decrement push
				busReq.wdata = (state == sPushHi) ? pc[15:8] : pc[7:0];
				busReq.we = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sFetch;
			dataPhase <= 1'b0;
			pc <= 16'h0000;
			sp <= sm83Pkg::resetSp;
			flags <= '0;
			ime <= 1'b0;
			eiDelay <= 1'b0;
		end else if (busRequest) begin
			dataPhase <= busGrant;  // Holds while the DMA owns the bus
		end else begin
			dataPhase <= 1'b0;
			case (state)
				sFetch: begin
					ir <= fetched;
					pc <= pc + 16'd1;
					state <= sBoundary;  // EI, DI and NOP-like bytes
					if (fetched.raw == 8'h3E || (fetched.f.x == 2'd3 && fetched.f.z == 3'd6))
						state <= sImm;     // LD A,d8 or ALU d8
					else if (fetched.raw inside {8'hC3, 8'hEA, 8'hFA})
						state <= sAddrLo;
					else if (fetched.raw == 8'h76)
						state <= sHalt;
					else if (fetched.raw == 8'hD9)
						state <= sPopLo;   // RETI
					if (fetched.raw == 8'hFB)
						eiDelay <= 1'b1;
					if (fetched.raw == 8'hF3) begin
						ime <= 1'b0;
						eiDelay <= 1'b0;
					end
				end
				sImm: begin
					pc <= pc + 16'd1;
					state <= sBoundary;
					if (ir.raw == 8'h3E) begin
						acc <= rdata;
					end else begin
						acc <= aluResult;  // CP hands back A unchanged
						flags <= aluFlags;
					end
				end
				sAddrLo: begin
					addrReg[7:0] <= rdata;
					pc <= pc + 16'd1;
					state <= sAddrHi;
				end
				sAddrHi: begin
					addrReg[15:8] <= rdata;
					pc <= pc + 16'd1;
					state <= (ir.raw == 8'hEA) ? sMemWrite : sMemRead;
					if (ir.raw == 8'hC3) begin
						pc <= {rdata, addrReg[7:0]};  // JP a16
						state <= sBoundary;
					end
				end
				sMemRead: begin
					acc <= rdata;
					state <= sBoundary;
				end
				sMemWrite: state <= sBoundary;
				sPopLo: begin
					addrReg[7:0] <= rdata;
					sp <= sp + 16'd1;
					state <= sPopHi;
				end
				sPopHi: begin
					pc <= {rdata, addrReg[7:0]};
					sp <= sp + 16'd1;
					ime <= 1'b1;          // RETI enables at once
					state <= sBoundary;
				end
				sIntA: state <= sIntB;    // Two internal cycles
				sIntB: state <= sPushHi;
				sPushHi: begin
					sp <= sp - 16'd1;
					state <= sPushLo;
				end
				sPushLo: begin
					sp <= sp - 16'd1;
					pc <= sm83Pkg::vectorBase + {10'd0, irqLine, 3'b000};
					state <= sFetch;
				end
				sHalt: if (irqValid) state <= sBoundary;  // Wakes even with IME clear
				default: begin
					state <= sFetch;
					if (eiDelay) begin
						ime <= 1'b1;
						eiDelay <= 1'b0;
					end
					if (irqAck) begin
						ime <= 1'b0;
						irqLine <= irqPending;
						state <= sIntA;
					end
				end
			endcase
		end
	end

	// Arbiter back-pressure must not disturb a waiting request
	reqHeld: assert property (@(posedge clk) disable iff (reset)
		busRequest && !busGrant |=> busRequest && $stable(busReq));

endmodule

`default_nettype wire

//--- verilog/sm83Alu.sv
`timescale 1ns/100ps
`default_nettype none

module sm83Alu (
	input wire sm83Pkg::aluOpE op,
	input wire logic [7:0] a,
	input wire logic [7:0] b,
	input wire logic carryIn,
	output logic [7:0] result,
	output sm83Pkg::flagsT flags
);

	logic cin;                  // Carry only for ADC and SBC
	logic subtract;
	logic [4:0] halfSum;        // Bit 4 is the half carry or borrow
	logic [8:0] fullSum;        // Bit 8 is the carry or borrow
	logic [7:0] value;

	assign cin = (op == sm83Pkg::aluAdc || op == sm83Pkg::aluSbc) ? carryIn : 1'b0;
	assign subtract = op inside {sm83Pkg::aluSub, sm83Pkg::aluSbc, sm83Pkg::aluCp};

	always_comb begin
		halfSum = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
		fullSum = {1'b0, a} + {1'b0, b} + {8'd0, cin};
		if (subtract) begin
			halfSum = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
			fullSum = {1'b0, a} - {1'b0, b} - {8'd0, cin};  // Wraps, so bit 8 is borrow
		end
		value = fullSum[7:0];
		flags.n = subtract;
		flags.h = halfSum[4];
		flags.c = fullSum[8];
		case (op)
			sm83Pkg::aluAnd: begin
				value = a & b;
				flags.h = 1'b1;        // AND always sets H
				flags.c = 1'b0;
			end
			sm83Pkg::aluXor: begin
				value = a ^ b;
				flags.h = 1'b0;
				flags.c = 1'b0;
			end
			sm83Pkg::aluOr: begin
				value = a | b;
				flags.h = 1'b0;
				flags.c = 1'b0;
			end
			default: ;
		endcase
		flags.z = (value == 8'd0);
		result = (op == sm83Pkg::aluCp) ? a : value;  // CP keeps A
	end

endmodule

`default_nettype wire

//--- verilog/sm83Pkg.sv
`default_nettype none

package sm83Pkg;

	// One master's bus request
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] wdata;
		logic we;                  // High for a write
	} busReqT;

	// Opcode byte, read whole or split into x/y/z fields
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] x;
			logic [2:0] y;         // ALU operation in the 8-bit ALU group
			logic [2:0] z;
		} f;
	} opcodeU;

	// Same order as the y field of the ALU group
	typedef enum logic [2:0] {
		aluAdd, aluAdc, aluSub, aluSbc, aluAnd, aluXor, aluOr, aluCp
	} aluOpE;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flagsT;

	localparam logic [15:0] addrSerial = 16'hFF01;  // SB
	localparam logic [15:0] addrIf = 16'hFF0F;
	localparam logic [15:0] addrIe = 16'hFFFF;
	localparam logic [15:0] addrDma = 16'hFF46;
	localparam logic [15:0] oamBase = 16'h0E00;     // DMA destination
	localparam int dmaLength = 16;
	localparam int irqCount = 5;
	localparam logic [15:0] vectorBase = 16'h0040;
	localparam int ramBytes = 4096;
	localparam logic [15:0] resetSp = 16'h0FFE;

endpackage

`default_nettype wire
